//--- wakeup_pkg.sv
package wakeup_pkg;

    // data path width of the integer core.
    localparam int xlen = 32;

    // physical register index width and the register count it gives.
    localparam int preg_width = 6;
    localparam int preg_num = 1 << preg_width;

    typedef logic [xlen-1:0] word_t;
    typedef logic [preg_width-1:0] preg_t;

    // one instruction picked by an issue queue.
    // loads read rs1 only, stores read rs1 and rs2 and write no rd.
    typedef struct packed {
        logic  valid;
        preg_t rd;
        preg_t rs1;
        preg_t rs2;
    } issue_req_t;

    // a CSR instruction borrows ALU lane 1 for its rs1 read and its rd wakeup.
    typedef struct packed {
        logic  valid;
        preg_t rd;
        preg_t rs1;
    } csr_req_t;

    // one slot of the wakeup bus seen by the issue queues.
    typedef struct packed {
        logic  valid;
        logic  we;    // rd is a real destination, not register 0.
        preg_t rd;
    } wakeup_t;

    // one result on the writeback bus.
    typedef struct packed {
        logic  valid;
        preg_t rd;
        word_t data;
    } wb_t;

    // operand pair returned to an ALU lane or a store pipe.
    typedef struct packed {
        word_t rs1_data;
        word_t rs2_data;
    } operands_t;

endpackage

//--- int_wakeup_port.sv
`timescale 1ns/1ns

module int_wakeup_port #(
    parameter int alu_size = 2
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  wakeup_pkg::issue_req_t [alu_size-1:0]      int_req,
    input  wakeup_pkg::csr_req_t                       csr_req,
    output logic                                       csr_ready,
    output wakeup_pkg::wakeup_t [alu_size-1:0]         wakeup,
    output logic [alu_size*2-1:0]                      rd_en,
    output wakeup_pkg::preg_t [alu_size*2-1:0]         rd_addr
);
    import wakeup_pkg::*;

    issue_req_t [alu_size-1:0] lane_d;
    logic [alu_size-1:0]       valid_q;
    preg_t [alu_size-1:0]      rd_q;
    preg_t [alu_size-1:0]      rs1_q;
    preg_t [alu_size-1:0]      rs2_q;

    // lane 1 is not free while a CSR instruction is being issued.
    assign csr_ready = ~csr_req.valid;

    always_comb begin
        lane_d = int_req;
        if (csr_req.valid) begin
            // the CSR replaces the ALU request, whose issuer holds it for later.
            lane_d[1].valid = 1'b1;
            lane_d[1].rd = csr_req.rd;
            lane_d[1].rs1 = csr_req.rs1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < alu_size; i++) begin
                valid_q[i] <= lane_d[i].valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < alu_size; i++) begin
            rd_q[i] <= lane_d[i].rd;
            rs1_q[i] <= lane_d[i].rs1;
            rs2_q[i] <= lane_d[i].rs2;
        end
    end

    // rs1 reads take the low ports and rs2 reads the ports above them.
    for (genvar i = 0; i < alu_size; i++) begin : g_lane
        assign wakeup[i].valid = valid_q[i];
        assign wakeup[i].we = rd_q[i] != '0;
        assign wakeup[i].rd = rd_q[i];
        assign rd_en[i] = valid_q[i];
        assign rd_en[alu_size+i] = valid_q[i];
        assign rd_addr[i] = rs1_q[i];
        assign rd_addr[alu_size+i] = rs2_q[i];
    end

    // the wakeup slot after a CSR request belongs to the CSR, whatever lane 1 asked for.
    csr_owns_lane1: assert property (
        @(posedge clk) disable iff (!rst_n)
        csr_req.valid |=> (wakeup[1].valid && wakeup[1].rd == $past(csr_req.rd))
    );

endmodule

//--- mem_wakeup_port.sv
`timescale 1ns/1ns

module mem_wakeup_port #(
    parameter int load_pipes  = 1,
    parameter int store_pipes = 1
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  wakeup_pkg::issue_req_t [load_pipes-1:0]              load_req,
    input  wakeup_pkg::issue_req_t [store_pipes-1:0]             store_req,
    output wakeup_pkg::wakeup_t [load_pipes-1:0]                 wakeup,
    output logic [load_pipes+store_pipes*2-1:0]                  rd_en,
    output wakeup_pkg::preg_t [load_pipes+store_pipes*2-1:0]     rd_addr
);
    localparam int store_base = load_pipes;

    // a load wakes its consumers in the same cycle it issues.
    for (genvar j = 0; j < load_pipes; j++) begin : g_load
        assign wakeup[j].valid = load_req[j].valid;
        assign wakeup[j].we = load_req[j].rd != '0;
        assign wakeup[j].rd = load_req[j].rd;
        assign rd_en[j] = load_req[j].valid;
        assign rd_addr[j] = load_req[j].valid ? load_req[j].rs1 : '0; // idle ports sit on r0.
    end

    for (genvar j = 0; j < store_pipes; j++) begin : g_store
        localparam int s1 = store_base + j;
        localparam int s2 = store_base + store_pipes + j;

        assign rd_en[s1] = store_req[j].valid;
        assign rd_en[s2] = store_req[j].valid;
        assign rd_addr[s1] = store_req[j].valid ? store_req[j].rs1 : '0;
        assign rd_addr[s2] = store_req[j].valid ? store_req[j].rs2 : '0;

        // an enabled store pair must carry two known register indexes.
        store_addr_known: assert property (
            @(posedge clk) disable iff (!rst_n)
            rd_en[s1] |-> !$isunknown({rd_addr[s1], rd_addr[s2]})
        );
    end

endmodule

//--- phys_regfile.sv
`timescale 1ns/1ns

module phys_regfile #(
    parameter int read_ports = 10,
    parameter int wb_size    = 3
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [read_ports-1:0]                   rd_en,
    input  wakeup_pkg::preg_t [read_ports-1:0]      rd_addr,
    input  wakeup_pkg::wb_t [wb_size-1:0]           wb,
    output wakeup_pkg::word_t [read_ports-1:0]      rd_data
);
    import wakeup_pkg::*;

    word_t                  regs [preg_num];
    logic [wb_size-1:0]     wr_en;
    word_t [read_ports-1:0] rd_fwd;

    // register 0 is hardwired, so a writeback to it is dropped.
    always_comb begin
        for (int k = 0; k < wb_size; k++) begin
            wr_en[k] = wb[k].valid && (wb[k].rd != '0);
        end
    end

    // a result written in the same cycle wins over the stored value.
    always_comb begin
        for (int p = 0; p < read_ports; p++) begin
            rd_fwd[p] = regs[rd_addr[p]];
            for (int k = 0; k < wb_size; k++) begin
                if (wr_en[k] && wb[k].rd == rd_addr[p]) begin
                    rd_fwd[p] = wb[k].data;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < preg_num; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int k = 0; k < wb_size; k++) begin
                if (wr_en[k]) begin
                    regs[wb[k].rd] <= wb[k].data;
                end
            end
        end
    end

    // each port holds its last value while it is not enabled.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else begin
            for (int p = 0; p < read_ports; p++) begin
                if (rd_en[p]) begin
                    rd_data[p] <= rd_fwd[p];
                end
            end
        end
    end

    // the execution units never produce two results for one register at once.
    for (genvar a = 0; a < wb_size; a++) begin : g_wb_a
        for (genvar b = a + 1; b < wb_size; b++) begin : g_wb_b
            wb_rd_unique: assert property (
                @(posedge clk) disable iff (!rst_n)
                !(wr_en[a] && wr_en[b] && wb[a].rd == wb[b].rd)
            );
        end
    end

endmodule

//--- wakeup_stage.sv
`timescale 1ns/1ns

module wakeup_stage #(
    parameter int alu_size    = 2,
    parameter int load_pipes  = 1,
    parameter int store_pipes = 1,
    parameter int wb_size     = 3
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  wakeup_pkg::issue_req_t [alu_size-1:0]               int_req,
    input  wakeup_pkg::csr_req_t                                csr_req,
    input  wakeup_pkg::issue_req_t [load_pipes-1:0]             load_req,
    input  wakeup_pkg::issue_req_t [store_pipes-1:0]            store_req,
    input  wakeup_pkg::wb_t [wb_size-1:0]                       wb,
    output wakeup_pkg::operands_t [alu_size-1:0]                int_ops,
    output logic [wakeup_pkg::xlen-1:0]                         csr_data,
    output logic [load_pipes-1:0][wakeup_pkg::xlen-1:0]         load_data,
    output wakeup_pkg::operands_t [store_pipes-1:0]             store_ops,
    output wakeup_pkg::wakeup_t [alu_size+load_pipes-1:0]       wakeup,
    output logic                                                csr_ready
);
    import wakeup_pkg::*;

    localparam int int_ports  = alu_size * 2;
    localparam int mem_ports  = load_pipes + store_pipes * 2;
    localparam int read_ports = int_ports + mem_ports;
    localparam int store_base = int_ports + load_pipes;

    logic [read_ports-1:0]  rd_en;
    preg_t [read_ports-1:0] rd_addr;
    word_t [read_ports-1:0] rd_data;

    int_wakeup_port #(.alu_size(alu_size)) int_port (
        .clk(clk), .rst_n(rst_n), .int_req(int_req), .csr_req(csr_req),
        .csr_ready(csr_ready), .wakeup(wakeup[alu_size-1:0]),
        .rd_en(rd_en[int_ports-1:0]), .rd_addr(rd_addr[int_ports-1:0])
    );

    mem_wakeup_port #(.load_pipes(load_pipes), .store_pipes(store_pipes)) mem_port (
        .clk(clk), .rst_n(rst_n), .load_req(load_req), .store_req(store_req),
        .wakeup(wakeup[alu_size+load_pipes-1:alu_size]),
        .rd_en(rd_en[read_ports-1:int_ports]), .rd_addr(rd_addr[read_ports-1:int_ports])
    );

    phys_regfile #(.read_ports(read_ports), .wb_size(wb_size)) regfile (
        .clk(clk), .rst_n(rst_n), .rd_en(rd_en), .rd_addr(rd_addr), .wb(wb),
        .rd_data(rd_data)
    );

    for (genvar i = 0; i < alu_size; i++) begin : g_int_ops
        assign int_ops[i].rs1_data = rd_data[i];
        assign int_ops[i].rs2_data = rd_data[alu_size+i];
    end

    assign csr_data = rd_data[1]; // the CSR operand comes back on lane 1's rs1 port.

    for (genvar j = 0; j < load_pipes; j++) begin : g_load_data
        assign load_data[j] = rd_data[int_ports+j];
    end

    for (genvar j = 0; j < store_pipes; j++) begin : g_store_ops
        assign store_ops[j].rs1_data = rd_data[store_base+j];
        assign store_ops[j].rs2_data = rd_data[store_base+store_pipes+j];
    end

endmodule

//--- tb_wakeup_checks.sv
`timescale 1ns/1ns

module tb_wakeup_checks #(
    parameter int alu_size    = 2,
    parameter int load_pipes  = 1,
    parameter int store_pipes = 1
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  wakeup_pkg::wakeup_t [alu_size+load_pipes-1:0]   wakeup,
    input  wakeup_pkg::wakeup_t [alu_size+load_pipes-1:0]   exp_wakeup,
    input  logic                                            csr_valid,
    input  logic                                            csr_ready,
    input  wakeup_pkg::operands_t [alu_size-1:0]            int_ops,
    input  wakeup_pkg::operands_t [alu_size-1:0]            exp_int_ops,
    input  logic [alu_size-1:0]                             int_chk,
    input  wakeup_pkg::word_t                               csr_data,
    input  wakeup_pkg::word_t                               exp_csr_data,
    input  logic                                            csr_chk,
    input  wakeup_pkg::word_t [load_pipes-1:0]              load_data,
    input  wakeup_pkg::word_t [load_pipes-1:0]              exp_load_data,
    input  logic [load_pipes-1:0]                           load_chk,
    input  wakeup_pkg::operands_t [store_pipes-1:0]         store_ops,
    input  wakeup_pkg::operands_t [store_pipes-1:0]         exp_store_ops,
    input  logic [store_pipes-1:0]                          store_chk,
    output int                                              errors
);
    import wakeup_pkg::*;

    int error_count = 0;
    logic [alu_size+load_pipes-1:0] wakeup_valid;

    assign errors = error_count;

    always_comb begin
        for (int i = 0; i < alu_size + load_pipes; i++) begin
            wakeup_valid[i] = wakeup[i].valid;
        end
    end

    // the wakeup bus stays quiet through reset and the cycle right after it.
    reset_idle: assert property (
        @(posedge clk) (!rst_n || !$past(rst_n)) |-> (wakeup_valid == '0)
    ) else begin
        error_count++;
        $display("ERROR at %0t ns: wakeup valid bits %b during reset", $time,
                 $sampled(wakeup_valid));
    end

    csr_ready_level: assert property (@(posedge clk) csr_ready == !csr_valid)
    else begin
        error_count++;
        $display("ERROR at %0t ns: csr_ready is %b with csr valid %b", $time,
                 $sampled(csr_ready), $sampled(csr_valid));
    end

    csr_operand: assert property (
        @(posedge clk) disable iff (!rst_n) csr_chk |-> csr_data == exp_csr_data
    ) else begin
        error_count++;
        $display("ERROR at %0t ns: csr_data is %h, expected %h", $time,
                 $sampled(csr_data), $sampled(exp_csr_data));
    end

    for (genvar i = 0; i < alu_size + load_pipes; i++) begin : g_wakeup
        wakeup_entry: assert property (
            @(posedge clk) disable iff (!rst_n)
            exp_wakeup[i].valid ? (wakeup[i] == exp_wakeup[i]) : !wakeup[i].valid
        ) else begin
            error_count++;
            $display("ERROR at %0t ns: wakeup[%0d] is %h, expected %h", $time, i,
                     $sampled(wakeup[i]), $sampled(exp_wakeup[i]));
        end
    end

    for (genvar i = 0; i < alu_size; i++) begin : g_int_ops
        alu_operands: assert property (
            @(posedge clk) disable iff (!rst_n) int_chk[i] |-> int_ops[i] == exp_int_ops[i]
        ) else begin
            error_count++;
            $display("ERROR at %0t ns: int_ops[%0d] is %h, expected %h", $time, i,
                     $sampled(int_ops[i]), $sampled(exp_int_ops[i]));
        end
    end

    for (genvar j = 0; j < load_pipes; j++) begin : g_load
        load_operand: assert property (
            @(posedge clk) disable iff (!rst_n) load_chk[j] |-> load_data[j] == exp_load_data[j]
        ) else begin
            error_count++;
            $display("ERROR at %0t ns: load_data[%0d] is %h, expected %h", $time, j,
                     $sampled(load_data[j]), $sampled(exp_load_data[j]));
        end
    end

    for (genvar j = 0; j < store_pipes; j++) begin : g_store
        store_operands: assert property (
            @(posedge clk) disable iff (!rst_n) store_chk[j] |-> store_ops[j] == exp_store_ops[j]
        ) else begin
            error_count++;
            $display("ERROR at %0t ns: store_ops[%0d] is %h, expected %h", $time, j,
                     $sampled(store_ops[j]), $sampled(exp_store_ops[j]));
        end
    end

endmodule

//--- tb_wakeup_stage.sv
`timescale 1ns/1ns

module tb_wakeup_stage;
    import wakeup_pkg::*;

    localparam int alu_size    = 2;
    localparam int load_pipes  = 1;
    localparam int store_pipes = 1;
    localparam int wb_size     = 3;
    localparam int run_cycles  = 2000;

    logic clk;
    logic rst_n;
    issue_req_t [alu_size-1:0]              int_req;
    csr_req_t                               csr_req;
    issue_req_t [load_pipes-1:0]            load_req;
    issue_req_t [store_pipes-1:0]           store_req;
    wb_t [wb_size-1:0]                      wb;
    operands_t [alu_size-1:0]               int_ops;
    word_t                                  csr_data;
    logic [load_pipes-1:0][xlen-1:0]        load_data;
    operands_t [store_pipes-1:0]            store_ops;
    wakeup_t [alu_size+load_pipes-1:0]      wakeup;
    logic                                   csr_ready;

    // reference model state.
    word_t                              shadow [preg_num];
    issue_req_t [alu_size-1:0]          lane_eff;
    issue_req_t [alu_size-1:0]          int_d1;
    issue_req_t [alu_size-1:0]          int_d2;
    csr_req_t                           csr_d1;
    csr_req_t                           csr_d2;
    issue_req_t [load_pipes-1:0]        load_d1;
    issue_req_t [store_pipes-1:0]       store_d1;
    wakeup_t [alu_size+load_pipes-1:0]  exp_wakeup;
    operands_t [alu_size-1:0]           exp_int_ops;
    logic [alu_size-1:0]                int_chk;
    word_t                              exp_csr_data;
    logic                               csr_chk;
    word_t [load_pipes-1:0]             exp_load_data;
    logic [load_pipes-1:0]              load_chk;
    operands_t [store_pipes-1:0]        exp_store_ops;
    logic [store_pipes-1:0]             store_chk;
    int                                 errors;
    bit                                 released;

    wakeup_stage #(
        .alu_size(alu_size), .load_pipes(load_pipes),
        .store_pipes(store_pipes), .wb_size(wb_size)
    ) uut (
        .clk(clk), .rst_n(rst_n), .int_req(int_req), .csr_req(csr_req),
        .load_req(load_req), .store_req(store_req), .wb(wb), .int_ops(int_ops),
        .csr_data(csr_data), .load_data(load_data), .store_ops(store_ops),
        .wakeup(wakeup), .csr_ready(csr_ready)
    );

    tb_wakeup_checks #(
        .alu_size(alu_size), .load_pipes(load_pipes), .store_pipes(store_pipes)
    ) checks (
        .clk(clk), .rst_n(rst_n), .wakeup(wakeup), .exp_wakeup(exp_wakeup),
        .csr_valid(csr_req.valid), .csr_ready(csr_ready),
        .int_ops(int_ops), .exp_int_ops(exp_int_ops), .int_chk(int_chk),
        .csr_data(csr_data), .exp_csr_data(exp_csr_data), .csr_chk(csr_chk),
        .load_data(load_data), .exp_load_data(exp_load_data), .load_chk(load_chk),
        .store_ops(store_ops), .exp_store_ops(exp_store_ops), .store_chk(store_chk),
        .errors(errors)
    );

    always #50 clk = ~clk;

    // a CSR request takes lane 1 but keeps the ALU's rs2 slot.
    always_comb begin
        lane_eff = int_req;
        if (csr_req.valid) begin
            lane_eff[1].valid = 1'b1;
            lane_eff[1].rd = csr_req.rd;
            lane_eff[1].rs1 = csr_req.rs1;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < preg_num; r++) begin
                shadow[r] <= '0;
            end
            int_d1 <= '0;
            int_d2 <= '0;
            csr_d1 <= '0;
            csr_d2 <= '0;
            load_d1 <= '0;
            store_d1 <= '0;
        end else begin
            for (int k = 0; k < wb_size; k++) begin
                if (wb[k].valid && wb[k].rd != '0) begin
                    shadow[wb[k].rd] <= wb[k].data;
                end
            end
            int_d1 <= lane_eff;
            int_d2 <= int_d1;
            csr_d1 <= csr_req;
            csr_d2 <= csr_d1;
            load_d1 <= load_req;
            store_d1 <= store_req;
        end
    end

    always_comb begin
        for (int i = 0; i < alu_size; i++) begin
            exp_wakeup[i].valid = int_d1[i].valid;
            exp_wakeup[i].we = int_d1[i].rd != '0;
            exp_wakeup[i].rd = int_d1[i].rd;
            exp_int_ops[i].rs1_data = shadow[int_d2[i].rs1];
            exp_int_ops[i].rs2_data = shadow[int_d2[i].rs2];
            int_chk[i] = int_d2[i].valid && !(i == 1 && csr_d2.valid);
        end
        for (int j = 0; j < load_pipes; j++) begin
            exp_wakeup[alu_size+j].valid = load_req[j].valid; // loads wake up at once.
            exp_wakeup[alu_size+j].we = load_req[j].rd != '0;
            exp_wakeup[alu_size+j].rd = load_req[j].rd;
            exp_load_data[j] = shadow[load_d1[j].rs1];
            load_chk[j] = load_d1[j].valid;
        end
        for (int j = 0; j < store_pipes; j++) begin
            exp_store_ops[j].rs1_data = shadow[store_d1[j].rs1];
            exp_store_ops[j].rs2_data = shadow[store_d1[j].rs2];
            store_chk[j] = store_d1[j].valid;
        end
        exp_csr_data = shadow[csr_d2.rs1];
        csr_chk = csr_d2.valid;
    end

    function automatic issue_req_t random_req();
        issue_req_t req;
        req.valid = ($urandom % 4) != 0;
        req.rd = preg_t'($urandom % 8); // few registers, so hazards are common.
        req.rs1 = preg_t'($urandom % 8);
        req.rs2 = preg_t'($urandom % 8);
        return req;
    endfunction

    task automatic drive_idle();
        int_req = '0;
        csr_req = '0;
        load_req = '0;
        store_req = '0;
        wb = '0;
    endtask

    task automatic drive_random();
        issue_req_t lane1_keep;
        bit hold_lane1;
        int base;
        lane1_keep = int_req[1];
        hold_lane1 = csr_req.valid; // the issuer retries a request the CSR pushed aside.
        for (int i = 0; i < alu_size; i++) begin
            int_req[i] = random_req();
        end
        if (hold_lane1) begin
            int_req[1] = lane1_keep;
        end
        csr_req.valid = ($urandom % 4) == 0;
        csr_req.rd = preg_t'($urandom % 8);
        csr_req.rs1 = preg_t'($urandom % 8);
        for (int j = 0; j < load_pipes; j++) begin
            load_req[j] = random_req();
        end
        for (int j = 0; j < store_pipes; j++) begin
            store_req[j] = random_req();
        end
        // steps of 3 modulo 8 keep the writeback targets apart.
        base = $urandom % 8;
        for (int k = 0; k < wb_size; k++) begin
            wb[k].valid = ($urandom % 4) != 0;
            wb[k].rd = preg_t'((base + k * 3) % 8);
            wb[k].data = $urandom;
        end
    endtask

    task automatic wait_reset_release(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < 20 && !ok; n++) begin
            @(posedge clk);
            ok = (rst_n === 1'b1);
        end
        if (!ok) begin
            $display("timed out waiting for the DUT to leave reset");
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        drive_idle();
        void'($urandom(32'h07e0eada));
        // ALU and CSR traffic during reset must not reach the wakeup bus.
        repeat (10) begin
            @(posedge clk);
            #5 drive_random();
            load_req = '0; // a load wakes up combinationally, so none issues in reset.
        end
        rst_n = 1'b1;
        wait_reset_release(released);
        if (released) begin
            repeat (run_cycles) begin
                #5 drive_random();
                @(posedge clk);
            end
            #5 drive_idle();
            repeat (3) @(posedge clk); // drain the two-cycle operand pipeline.
        end
        $display("cycles run: %0d, errors: %0d", released ? run_cycles : 0, errors);
        if (released && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
wakeup_pkg.sv
int_wakeup_port.sv
mem_wakeup_port.sv
phys_regfile.sv
wakeup_stage.sv
tb_wakeup_checks.sv
tb_wakeup_stage.sv

//--- Makefile
TOP = tb_wakeup_stage
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
